//--- flist.f
+incdir+source
source/icache_pkg.sv
source/mem_bus_pkg.sv
source/icache_tag_store.sv
source/icache_data_store.sv
source/icache_ctrl.sv
source/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/icache_tb.sv
// Self-checking testbench; expects memory data equal to the inverted word address, one fetch at a time
`default_nettype none

`include "icache_defs.svh"

module icache_tb
    import icache_pkg::*;
    import mem_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LINES = 1 << `ICACHE_INDEX_W;

    logic        clk;
    logic        rst;
    fetch_req_t  fetch_req;
    fetch_rsp_t  fetch_rsp;
    refill_req_t refill_req;
    refill_rsp_t refill_rsp;
    int          beat_total;

    // Expectations for the fetch in flight, only changed on the falling edge
    addr_t exp_line;
    word_t exp_data;
    logic  expect_miss;
    int    start_beats;

    // Resident tag per index
    tag_t model_tag [LINES];
    logic model_valid [LINES];

    int   errors;
    int   errors_at_start;
    int   hits;
    int   misses;
    int   tests_passed;
    int   tests_failed;
    logic hung;

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    icache_top i_icache_top (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp),
        .refill_req (refill_req),
        .refill_rsp (refill_rsp)
    );

    icache_mem_model i_mem_model (
        .clk        (clk),
        .rst        (rst),
        .refill_req (refill_req),
        .refill_rsp (refill_rsp),
        .beat_total (beat_total)
    );

    // ======================================================================
    // Checks
    // ======================================================================

    function void flag_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED @ %0t ns: %s", $time, msg);
    endfunction

    reset_idle: assert property (
        @(posedge clk) rst || $past(rst) |-> !fetch_rsp.stall && !refill_req.req
    ) else flag_mismatch("wait or memory request high around reset");

    // Wait falls only at the end of DONE
    fetch_data: assert property (
        @(posedge clk) disable iff (rst)
        $fell(fetch_rsp.stall) |-> fetch_rsp.data == exp_data
    ) else flag_mismatch($sformatf("fetched word %h, expected %h", fetch_rsp.data, exp_data));

    refill_line_addr: assert property (
        @(posedge clk) disable iff (rst)
        refill_req.req |-> refill_req.addr == exp_line
    ) else flag_mismatch($sformatf("refill address %h, expected %h", refill_req.addr, exp_line));

    refill_on_miss_only: assert property (
        @(posedge clk) disable iff (rst)
        refill_req.req |-> expect_miss
    ) else flag_mismatch("memory request raised on a predicted hit");

    refill_beats_bounded: assert property (
        @(posedge clk) disable iff (rst)
        refill_req.req |-> (beat_total - start_beats) < `ICACHE_WORDS
    ) else flag_mismatch("memory request still high after a full line");

    refill_beats_total: assert property (
        @(posedge clk) disable iff (rst)
        $fell(fetch_rsp.stall) |->
            (beat_total - start_beats) == (expect_miss ? `ICACHE_WORDS : 0)
    ) else flag_mismatch($sformatf("%0d refill beats, miss predicted %0b",
                                   beat_total - start_beats, expect_miss));

    // Wait high for exactly two sampled cycles on a hit
    hit_two_cycles: assert property (
        @(posedge clk) disable iff (rst)
        $fell(fetch_rsp.stall) && !expect_miss |->
            $past(fetch_rsp.stall, 2) && !$past(fetch_rsp.stall, 3)
    ) else flag_mismatch("hit did not complete two cycles after the request");

    // ======================================================================
    // Stimulus
    // ======================================================================

    task automatic fetch(input addr_t addr);
        int     waited;
        index_t idx;
        tag_t   tag;
        idx = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        tag = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        @(negedge clk);
        if (!hung) begin
            exp_data    = ~(addr & ~addr_t'(3));
            exp_line    = addr & ~addr_t'((1 << `ICACHE_OFFSET_W) - 1);
            expect_miss = !model_valid[idx] || (model_tag[idx] != tag);
            start_beats = beat_total;
            fetch_req.req  = 1'b1;
            fetch_req.addr = addr;
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (fetch_rsp.stall && waited < `ICACHE_TIMEOUT);
            if (fetch_rsp.stall) begin
                hung = 1'b1;
                $display("Timeout: wait level still high after %0d cycles for address %h",
                         waited, addr);
            end
            fetch_req.req    = 1'b0;
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            if (expect_miss) begin
                misses++;
            end else begin
                hits++;
            end
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
        hits = 0;
        misses = 0;
    endtask

    task automatic end_test(input string name);
        // Last DONE cycle still has to pass the checks
        repeat (2) @(negedge clk);
        if (errors == errors_at_start && !hung) begin
            tests_passed++;
            $display("%-22s passed  (%0d hits, %0d misses)", name, hits, misses);
        end else begin
            tests_failed++;
            $display("%-22s failed  (%0d errors)", name, errors - errors_at_start);
        end
    endtask

    initial begin
        void'($urandom(57600));
        rst = 1'b1;
        fetch_req = '0;
        exp_line = '0;
        exp_data = '0;
        expect_miss = 1'b0;
        start_beats = 0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        hung = 1'b0;
        for (int i = 0; i < LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;

        start_test();
        fetch(32'h0000_1000);
        fetch(32'hffff_f3c8);
        end_test("reset and first fetch");

        start_test();
        fetch(32'h0000_2044);
        fetch(32'h8000_03fc);
        fetch(32'h0000_1238);
        end_test("cold misses");

        start_test();
        fetch(32'h0000_1004);
        fetch(32'h0000_100c);
        fetch(32'h0000_1000);
        fetch(32'h0000_2040);
        fetch(32'h0000_204c);
        fetch(32'h8000_03f0);
        end_test("hits on filled lines");

        // Same index 0x30, different tags
        start_test();
        for (int n = 0; n < 4; n++) begin
            fetch(32'h0000_0300);
            fetch(32'h0004_0308);
        end
        end_test("conflict eviction");

        // 2 KB range over a 1 KB cache gives hits and conflict misses
        start_test();
        for (int n = 0; n < 80; n++) begin
            fetch(addr_t'(($urandom % 512) * 4));
        end
        end_test("random fetches");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0 && !hung) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/icache_mem_model.sv
// Refill memory responder; one word per beat, random stalls, word data is the inverted byte address
`default_nettype none

`include "icache_defs.svh"

module icache_mem_model
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  refill_req_t refill_req,
    output refill_rsp_t refill_rsp,
    output int          beat_total
);

    timeunit 1ns;
    timeprecision 100ps;

    // Word of the line being served, lowest first
    word_sel_t beat_idx;

    // ======================================================================
    // Beat accounting
    // ======================================================================

    // A beat moves on a rising edge with req high and stall low
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_idx   <= '0;
            beat_total <= 0;
        end else if (refill_req.req && !refill_rsp.stall) begin
            beat_idx   <= beat_idx + 1'b1;
            beat_total <= beat_total + 1;
        end else if (!refill_req.req) begin
            beat_idx <= '0;
        end
    end

    // ======================================================================
    // Response drive
    // ======================================================================

    // New stall and data on each falling edge, roughly one cycle in three stalls
    initial begin
        refill_rsp = '0;
        forever begin
            @(negedge clk);
            refill_rsp.stall = ($urandom % 3) == 0;
            refill_rsp.data  = ~(refill_req.addr + (addr_t'(beat_idx) << 2));
        end
    end

endmodule

`default_nettype wire

//--- source/icache_top.sv
// Read-only instruction cache; fetch and refill ports use plain levels, no valid/ready
`default_nettype none

`include "icache_defs.svh"

module icache_top
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_req_t  fetch_req,
    output fetch_rsp_t  fetch_rsp,
    output refill_req_t refill_req,
    input  refill_rsp_t refill_rsp
);

    logic      lookup_en;
    logic      fill_en;
    logic      beat_en;
    logic      use_fill;
    logic      hit;
    index_t    cur_index;
    tag_t      cur_tag;
    word_sel_t word_sel;
    word_t     rdata;

    // ======================================================================
    // Stores
    // ======================================================================

    icache_tag_store i_tag_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (lookup_en),
        .lookup_index (cur_index),
        .lookup_tag   (cur_tag),
        .fill_en      (fill_en),
        .fill_index   (cur_index),
        .fill_tag     (cur_tag),
        .hit          (hit)
    );

    icache_data_store i_data_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (lookup_en),
        .lookup_index (cur_index),
        .word_sel     (word_sel),
        .beat_en      (beat_en),
        .beat_data    (refill_rsp.data),
        .fill_en      (fill_en),
        .fill_index   (cur_index),
        .use_fill     (use_fill),
        .rdata        (rdata)
    );

    // ======================================================================
    // Controller
    // ======================================================================

    icache_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp),
        .refill_req (refill_req),
        .refill_rsp (refill_rsp),
        .hit        (hit),
        .rdata      (rdata),
        .lookup_en  (lookup_en),
        .fill_en    (fill_en),
        .beat_en    (beat_en),
        .use_fill   (use_fill),
        .cur_index  (cur_index),
        .cur_tag    (cur_tag),
        .word_sel   (word_sel)
    );

endmodule

`default_nettype wire

//--- source/icache_ctrl.sv
// One fetch in flight at a time; the core must hold req and addr until wait drops
`default_nettype none

`include "icache_defs.svh"

module icache_ctrl
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fetch_req_t  fetch_req,
    output fetch_rsp_t  fetch_rsp,
    output refill_req_t refill_req,
    input  refill_rsp_t refill_rsp,
    input  logic        hit,
    input  word_t       rdata,
    output logic        lookup_en,
    output logic        fill_en,
    output logic        beat_en,
    output logic        use_fill,
    output index_t      cur_index,
    output tag_t        cur_tag,
    output word_sel_t   word_sel
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    addr_t     addr_q;
    beat_cnt_t beat_cnt;
    word_t     word_q;
    logic      beats_done;

    // ======================================================================
    // State machine
    // ======================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (fetch_req.req) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                state_nxt = hit ? DONE : REFILL;
            end
            REFILL: begin
                if (beats_done) begin
                    state_nxt = DONE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Request address, held for lookup compare and refill
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            addr_q <= fetch_req.addr;
        end
    end

    // ======================================================================
    // Refill beat counter
    // ======================================================================

    assign beats_done = (beat_cnt == beat_cnt_t'(`ICACHE_WORDS));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (beats_done) begin
            beat_cnt <= '0;
        end else if (beat_en) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // ======================================================================
    // Store strobes
    // ======================================================================

    assign lookup_en = (state == IDLE) && fetch_req.req;
    assign beat_en   = (state == REFILL) && !beats_done && !refill_rsp.stall;
    assign fill_en   = (state == REFILL) && beats_done;
    assign use_fill  = (state == REFILL);

    // In IDLE the index comes straight from the port so the read lands in LOOKUP
    assign cur_index = (state == IDLE) ? fetch_req.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]
                                       : addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign cur_tag   = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign word_sel  = addr_q[2 +: $bits(word_sel_t)];

    // ======================================================================
    // Core and memory outputs
    // ======================================================================

    // Word is taken on a hit in LOOKUP or once the line is complete
    always_ff @(posedge clk) begin
        if (((state == LOOKUP) && hit) || fill_en) begin
            word_q <= rdata;
        end
    end

    always_comb begin
        case (state)
            IDLE:    fetch_rsp.stall = fetch_req.req;
            DONE:    fetch_rsp.stall = 1'b0;
            default: fetch_rsp.stall = 1'b1;
        endcase
    end

    assign fetch_rsp.data = word_q;

    assign refill_req.req  = (state == REFILL) && !beats_done;
    assign refill_req.addr = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    // ======================================================================
    // Checks
    // ======================================================================

    // Memory request lives only in REFILL, entered from a missed LOOKUP
    mem_req_refill_only: assert property (
        @(posedge clk) disable iff (rst)
        refill_req.req |-> (state == REFILL) && ($past(state) inside {LOOKUP, REFILL})
    ) else $error("memory request outside REFILL");

    // A pending fetch never sees wait drop before DONE
    core_wait_held: assert property (
        @(posedge clk) disable iff (rst)
        fetch_req.req && (state inside {LOOKUP, REFILL}) |-> fetch_rsp.stall
    ) else $error("core wait low while fetch pending");

endmodule

`default_nettype wire

//--- source/icache_data_store.sv
// Line data for 64 lines; refill beats must arrive lowest word first
`default_nettype none

`include "icache_defs.svh"

module icache_data_store
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      lookup_en,
    input  index_t    lookup_index,
    input  word_sel_t word_sel,
    input  logic      beat_en,
    input  word_t     beat_data,
    input  logic      fill_en,
    input  index_t    fill_index,
    input  logic      use_fill,
    output word_t     rdata
);

    line_t line_mem [(1 << `ICACHE_INDEX_W)];
    line_t rd_line;
    line_t fill_line;

    // ======================================================================
    // Line memory and refill assembly
    // ======================================================================

    always_ff @(posedge clk) begin
        if (fill_en) begin
            line_mem[fill_index] <= fill_line;
        end
        if (lookup_en) begin
            rd_line <= line_mem[lookup_index];
        end
        // New beat enters at the top, so word 0 ends up lowest
        if (beat_en) begin
            fill_line <= {beat_data, fill_line[$bits(line_t)-1:$bits(word_t)]};
        end
    end

    // ======================================================================
    // Word select
    // ======================================================================

    // During a refill the memory copy is stale, take the assembled line
    always_comb begin
        if (use_fill) begin
            rdata = fill_line[word_sel*$bits(word_t) +: $bits(word_t)];
        end else begin
            rdata = rd_line[word_sel*$bits(word_t) +: $bits(word_t)];
        end
    end

    // Line write comes right after the last accepted beat
    fill_after_beat: assert property (
        @(posedge clk) disable iff (rst)
        fill_en |-> $past(beat_en) && !beat_en
    ) else $error("data store fill without a preceding beat");

endmodule

`default_nettype wire

//--- source/icache_tag_store.sv
// Tags and valid bits for 64 lines; lookup and fill must never share a cycle
`default_nettype none

`include "icache_defs.svh"

module icache_tag_store
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   lookup_en,
    input  index_t lookup_index,
    input  tag_t   lookup_tag,
    input  logic   fill_en,
    input  index_t fill_index,
    input  tag_t   fill_tag,
    output logic   hit
);

    tag_t tag_mem [(1 << `ICACHE_INDEX_W)];
    tag_t tag_q;

    logic [(1 << `ICACHE_INDEX_W)-1:0] valid;
    logic valid_q;

    // ======================================================================
    // Tag memory, registered read
    // ======================================================================

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_index] <= fill_tag;
        end
        if (lookup_en) begin
            tag_q <= tag_mem[lookup_index];
        end
    end

    // ======================================================================
    // Valid bits
    // ======================================================================

    // All lines invalid after reset, a fill marks its line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid   <= '0;
            valid_q <= 1'b0;
        end else begin
            if (fill_en) begin
                valid[fill_index] <= 1'b1;
            end
            if (lookup_en) begin
                valid_q <= valid[lookup_index];
            end
        end
    end

    // Compared against the captured tag in the cycle after the lookup strobe
    assign hit = valid_q && (tag_q == lookup_tag);

    // Controller only fills in REFILL and only looks up in IDLE
    lookup_fill_excl: assert property (
        @(posedge clk) disable iff (rst)
        lookup_en |-> !fill_en
    ) else $error("tag store saw lookup and fill together");

endmodule

`default_nettype wire

//--- source/mem_bus_pkg.sv
// Core and memory port bundles; plain levels only, the memory side has no write path
`default_nettype none

package mem_bus_pkg;

    import icache_pkg::*;

    // ======================================================================
    // Core fetch port
    // ======================================================================

    // Core holds req and addr steady until stall drops
    typedef struct packed {
        logic  req;
        addr_t addr;
    } fetch_req_t;

    // Wait level and the fetched word, word valid when stall is low in DONE
    typedef struct packed {
        logic  stall;
        word_t data;
    } fetch_rsp_t;

    // ======================================================================
    // Memory refill port
    // ======================================================================

    // Line-aligned address, req held for the whole refill
    typedef struct packed {
        logic  req;
        addr_t addr;
    } refill_req_t;

    // One word moves on each cycle with req high and stall low
    typedef struct packed {
        logic  stall;
        word_t data;
    } refill_rsp_t;

endpackage

`default_nettype wire

//--- source/icache_pkg.sv
// Cache geometry types; widths come from icache_defs.svh and are not meant to be overridden
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    // ======================================================================
    // Address and data
    // ======================================================================

    // Byte address as seen on the fetch port
    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

    // One instruction word
    typedef logic [`ICACHE_ADDR_W-1:0] word_t;

    // ======================================================================
    // Line geometry
    // ======================================================================

    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    // Word within a line, address bits just above the byte lane
    typedef logic [$clog2(`ICACHE_WORDS)-1:0] word_sel_t;

    // Whole line, word 0 in the low bits
    typedef logic [`ICACHE_WORDS*`ICACHE_ADDR_W-1:0] line_t;

    // One extra bit so the counter can sit at the full beat count
    typedef logic [$clog2(`ICACHE_WORDS):0] beat_cnt_t;

    // ======================================================================
    // Controller
    // ======================================================================

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/icache_defs.svh
// Geometry is fixed at 64 lines of 16 bytes over 32-bit addresses; change all widths together
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ======================================================================
// Address split
// ======================================================================

// Byte address and instruction word width
`define ICACHE_ADDR_W 32

// Line index, selects one of 64 lines
`define ICACHE_INDEX_W 6

// Byte offset inside a 16-byte line
`define ICACHE_OFFSET_W 4

// Words per line, one refill beat each
`define ICACHE_WORDS 4

// Whatever is left above index and offset
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// Upper bound in cycles for any testbench wait loop
`define ICACHE_TIMEOUT 400

`endif
